//--- build.f
+incdir+logic
+incdir+test
logic/simd_pkg.sv
logic/simd_issue_if.sv
logic/simd_intake.sv
logic/simd_lane.sv
logic/simd_writeback.sv
logic/simd_unit_top.sv
test/simd_tb.sv

//--- logic/simd_defs.svh
// SIMD unit sizing
`ifndef SIMD_DEFS_SVH
`define SIMD_DEFS_SVH

// Full vector register width in bits
`define SIMD_VLEN 128

// Number of 64-bit functional lanes
`define SIMD_LANES 2

// Width of one lane in bits
`define SIMD_ELEN 64

// Multiply latency below SEW 64
`define SIMD_MUL_LAT 2

// Multiply latency at SEW 64, also the deepest in-flight distance
`define SIMD_MUL64_LAT 3

`endif

//--- logic/simd_intake.sv
// SIMD instruction intake
`include "simd_defs.svh"

module simd_intake import simd_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    valid_i,
    input  vop_t                    op_i,
    input  sew_t                    sew_i,
    input  logic                    vx_form_i,
    input  logic [`SIMD_VLEN-1:0]   vs1_i,
    input  logic [`SIMD_VLEN-1:0]   vs2_i,
    input  logic [`SIMD_VLEN-1:0]   old_vd_i,
    input  logic [`SIMD_ELEN-1:0]   rs1_i,
    input  logic [`SIMD_VLEN/8-1:0] vm_i,
    input  logic [4:0]              dest_i,
    output logic                    ready_o,
    simd_issue_if.src               issue
);

    logic [1:0]            lat;
    logic                  accept;
    logic [2:0]            slot_q;   // Bit k set: a result lands k+1 edges ahead
    logic [2:0]            reserve;
    logic [5:0]            ew_mask;
    logic [`SIMD_VLEN-1:0] rs1_rep;

    always_comb begin
        if (op_i == VMUL) begin
            lat = (sew_i == SEW_64) ? 2'(`SIMD_MUL64_LAT) : 2'(`SIMD_MUL_LAT);
        end else begin
            lat = 2'd1;
        end
    end

    // Refuse when the completion slot is already claimed
    assign ready_o = ~slot_q[lat - 2'd1];
    assign accept  = valid_i & ready_o;
    assign reserve = accept ? (3'b001 << (lat - 2'd1)) : 3'b000;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slot_q <= '0;
        end else begin
            slot_q <= (slot_q | reserve) >> 1;  // Slots move one edge closer
        end
    end

    // Scalar replicated at element width
    always_comb begin
        case (sew_i)
            SEW_8:   ew_mask = 6'h07;
            SEW_16:  ew_mask = 6'h0f;
            SEW_32:  ew_mask = 6'h1f;
            default: ew_mask = 6'h3f;
        endcase
        for (int b = 0; b < `SIMD_VLEN; b++) begin
            rs1_rep[b] = rs1_i[6'(b) & ew_mask];
        end
    end

    assign issue.valid    = accept;
    assign issue.lane_op  = (op_i == VCNT) ? VSEQ : op_i;  // Lanes supply the equality flags
    assign issue.lane_sew = sew_i;
    assign issue.src1     = vx_form_i ? rs1_rep : vs1_i;
    assign issue.src2     = vs2_i;

    always_comb begin
        issue.desc.op        = op_i;
        issue.desc.sew       = sew_i;
        issue.desc.is_scalar = (op_i == VMV_X_S) || (op_i == VEXT) || (op_i == VCNT);
        issue.desc.dest      = dest_i;
        issue.desc.rs1       = rs1_i;
        issue.desc.vs2       = vs2_i;
        issue.desc.old_vd    = old_vd_i;
        issue.desc.vm        = vm_i;
        issue.desc.lat       = lat;
    end

endmodule

//--- logic/simd_issue_if.sv
// SIMD issue channel
`include "simd_defs.svh"

interface simd_issue_if import simd_pkg::*; ();

    logic                  valid;
    simd_desc_t            desc;
    vop_t                  lane_op;   // Operation as the lanes see it
    sew_t                  lane_sew;
    logic [`SIMD_VLEN-1:0] src1;      // Already replicated in vx form
    logic [`SIMD_VLEN-1:0] src2;

    modport src (
        output valid, desc, lane_op, lane_sew, src1, src2
    );

    modport lane (
        input valid, lane_op, lane_sew, src1, src2
    );

    modport wb (
        input valid, desc
    );

endinterface

//--- logic/simd_lane.sv
// SIMD 64-bit functional lane
`include "simd_defs.svh"

module simd_lane import simd_pkg::*; #(
    parameter int LANE_INDEX = 0
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    simd_issue_if.lane            issue,
    output logic [`SIMD_ELEN-1:0] result_o,
    output logic                  result_valid_o
);

    localparam int ELEN = `SIMD_ELEN;

    logic [ELEN-1:0]      op_a;
    logic [ELEN-1:0]      op_b;
    logic [3:0][ELEN-1:0] alu_w;    // One result per element width
    logic [3:0][ELEN-1:0] mul_w;
    logic [ELEN-1:0]      alu_res;
    logic [ELEN-1:0]      mul_res;
    logic                 alu_go;
    logic                 mul_go;

    // Multiplier pipeline
    logic                 s1_valid_q;
    logic                 s1_deep_q;  // One more stage needed before the result
    sew_t                 s1_sew_q;
    logic [ELEN-1:0]      s1_a_q;
    logic [ELEN-1:0]      s1_b_q;
    logic                 s2_valid_q;
    logic [ELEN-1:0]      s2_prod_q;
    logic [ELEN-1:0]      res_q;
    logic                 res_valid_q;

    assign op_a = issue.src1[LANE_INDEX*ELEN +: ELEN];
    assign op_b = issue.src2[LANE_INDEX*ELEN +: ELEN];

    // Element-wise datapath, no carries across element boundaries
    for (genvar w = 0; w < 4; w++) begin : g_sew
        localparam int EW = 8 << w;
        for (genvar e = 0; e < ELEN / EW; e++) begin : g_elem
            logic [EW-1:0] a;
            logic [EW-1:0] b;
            logic [EW-1:0] ma;
            logic [EW-1:0] mb;

            assign a  = op_a[e*EW +: EW];
            assign b  = op_b[e*EW +: EW];
            assign ma = s1_a_q[e*EW +: EW];
            assign mb = s1_b_q[e*EW +: EW];

            assign alu_w[w][e*EW +: EW] =
                (issue.lane_op == VADD) ? a + b :
                (issue.lane_op == VSUB) ? a - b :
                (issue.lane_op == VAND) ? a & b :
                (issue.lane_op == VXOR) ? a ^ b :
                (issue.lane_op == VSEQ) ? EW'(a == b) : '0;

            assign mul_w[w][e*EW +: EW] = ma * mb;  // Low half only
        end
    end

    assign alu_res = alu_w[issue.lane_sew];
    assign mul_res = mul_w[s1_sew_q];

    assign mul_go = issue.valid && (issue.lane_op == VMUL);
    assign alu_go = issue.valid && (issue.lane_op != VMUL);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q  <= 1'b0;
            s2_valid_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            s1_valid_q  <= mul_go;
            s2_valid_q  <= s1_valid_q & s1_deep_q;
            res_valid_q <= alu_go | (s1_valid_q & ~s1_deep_q) | s2_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_go) begin
            s1_a_q    <= op_a;
            s1_b_q    <= op_b;
            s1_sew_q  <= issue.lane_sew;
            s1_deep_q <= (issue.lane_sew == SEW_64);
        end
        if (s1_valid_q && s1_deep_q) begin
            s2_prod_q <= mul_res;
        end
        // Intake guarantees only one of these per edge
        if (alu_go) begin
            res_q <= alu_res;
        end else if (s1_valid_q && !s1_deep_q) begin
            res_q <= mul_res;
        end else if (s2_valid_q) begin
            res_q <= s2_prod_q;
        end
    end

    assign result_o       = res_q;
    assign result_valid_o = res_valid_q;

endmodule

//--- logic/simd_pkg.sv
// SIMD unit types
`include "simd_defs.svh"

package simd_pkg;

    // Element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,
        VAND    = 4'd2,
        VXOR    = 4'd3,
        VSEQ    = 4'd4,
        VMUL    = 4'd5,
        VMV_X_S = 4'd6,  // Element 0 to scalar
        VEXT    = 4'd7,  // Element rs1 to scalar
        VCNT    = 4'd8   // Leading run of equal elements
    } vop_t;

    // Everything the writeback needs once the lanes are done
    typedef struct packed {
        vop_t                    op;
        sew_t                    sew;
        logic                    is_scalar;
        logic [4:0]              dest;
        logic [`SIMD_ELEN-1:0]   rs1;
        logic [`SIMD_VLEN-1:0]   vs2;
        logic [`SIMD_VLEN-1:0]   old_vd;
        logic [`SIMD_VLEN/8-1:0] vm;     // One bit per element
        logic [1:0]              lat;    // Cycles until completion
    } simd_desc_t;

endpackage

//--- logic/simd_unit_top.sv
// SIMD execution unit
`include "simd_defs.svh"

module simd_unit_top import simd_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    valid_i,
    input  vop_t                    op_i,
    input  sew_t                    sew_i,
    input  logic                    vx_form_i,
    input  logic [`SIMD_VLEN-1:0]   vs1_i,
    input  logic [`SIMD_VLEN-1:0]   vs2_i,
    input  logic [`SIMD_VLEN-1:0]   old_vd_i,
    input  logic [`SIMD_ELEN-1:0]   rs1_i,
    input  logic [`SIMD_VLEN/8-1:0] vm_i,
    input  logic [4:0]              dest_i,
    output logic                    ready_o,
    output logic                    vec_valid_o,
    output logic [`SIMD_VLEN-1:0]   vd_o,
    output logic [4:0]              vec_dest_o,
    output logic                    scalar_valid_o,
    output logic [`SIMD_ELEN-1:0]   rd_result_o,
    output logic [4:0]              scalar_dest_o
);

    logic [`SIMD_LANES-1:0][`SIMD_ELEN-1:0] lane_result;
    logic [`SIMD_LANES-1:0]                 lane_valid;

    simd_issue_if issue_if ();

    simd_intake simd_intake_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .valid_i   (valid_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .vx_form_i (vx_form_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .old_vd_i  (old_vd_i),
        .rs1_i     (rs1_i),
        .vm_i      (vm_i),
        .dest_i    (dest_i),
        .ready_o   (ready_o),
        .issue     (issue_if.src)
    );

    // One lane per 64-bit slice
    for (genvar l = 0; l < `SIMD_LANES; l++) begin : g_lane
        simd_lane #(
            .LANE_INDEX (l)
        ) simd_lane_i (
            .clk_i          (clk_i),
            .rstn_i         (rstn_i),
            .issue          (issue_if.lane),
            .result_o       (lane_result[l]),
            .result_valid_o (lane_valid[l])
        );
    end

    simd_writeback simd_writeback_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .issue          (issue_if.wb),
        .lane_result_i  (lane_result),
        .lane_valid_i   (lane_valid),
        .vec_valid_o    (vec_valid_o),
        .vd_o           (vd_o),
        .vec_dest_o     (vec_dest_o),
        .scalar_valid_o (scalar_valid_o),
        .rd_result_o    (rd_result_o),
        .scalar_dest_o  (scalar_dest_o)
    );

endmodule

//--- logic/simd_writeback.sv
// SIMD result writeback
`include "simd_defs.svh"

module simd_writeback import simd_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    simd_issue_if.wb                               issue,
    input  logic [`SIMD_LANES-1:0][`SIMD_ELEN-1:0] lane_result_i,
    input  logic [`SIMD_LANES-1:0]                 lane_valid_i,
    output logic                                   vec_valid_o,
    output logic [`SIMD_VLEN-1:0]                  vd_o,
    output logic [4:0]                             vec_dest_o,
    output logic                                   scalar_valid_o,
    output logic [`SIMD_ELEN-1:0]                  rd_result_o,
    output logic [4:0]                             scalar_dest_o
);

    localparam int DEPTH = `SIMD_MUL64_LAT;
    localparam int VLEN  = `SIMD_VLEN;

    simd_desc_t            dl_q [DEPTH];
    logic [DEPTH-1:0]      dl_valid_q;
    simd_desc_t            cur;
    logic                  hit;
    logic                  done;
    logic [VLEN-1:0]       fu_vd;

    // Descriptor delay line, entry k holds what was accepted k+1 edges ago
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dl_valid_q <= '0;
        end else begin
            dl_valid_q <= {dl_valid_q[DEPTH-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk_i) begin
        dl_q[0] <= issue.desc;
        for (int k = 1; k < DEPTH; k++) begin
            dl_q[k] <= dl_q[k-1];
        end
    end

    // Pick the entry whose latency has just run out
    always_comb begin
        hit = 1'b0;
        cur = dl_q[0];
        for (int k = 0; k < DEPTH; k++) begin
            if (dl_valid_q[k] && (dl_q[k].lat == 2'(k + 1))) begin
                hit = 1'b1;
                cur = dl_q[k];
            end
        end
    end

    assign done  = hit & (&lane_valid_i);
    assign fu_vd = lane_result_i;

    // Masked elements keep the old destination value
    always_comb begin
        for (int b = 0; b < VLEN; b++) begin
            vd_o[b] = cur.vm[b >> (3 + int'(cur.sew))] ? fu_vd[b] : cur.old_vd[b];
        end
    end

    always_comb begin
        int   ew;
        int   ecount;
        int   base;
        logic run;

        ew          = 8 << cur.sew;
        ecount      = VLEN / ew;
        base        = (cur.op == VEXT) ? int'(cur.rs1[3:0]) * ew : 0;
        run         = 1'b1;
        rd_result_o = '0;
        case (cur.op)
            VMV_X_S, VEXT: begin
                // Out of range index reads as zero
                if (cur.op != VEXT || cur.rs1 < 64'(ecount)) begin
                    for (int b = 0; b < `SIMD_ELEN; b++) begin
                        if (b < ew) begin
                            rd_result_o[b] = cur.vs2[base + b];
                        end
                    end
                end
            end
            VCNT: begin
                for (int i = 0; i < VLEN / 8; i++) begin
                    if (i < ecount) begin
                        if (run && fu_vd[i * ew]) begin
                            rd_result_o = rd_result_o + 1'b1;
                        end else begin
                            run = 1'b0;  // Run ends at the first mismatch
                        end
                    end
                end
            end
            default: rd_result_o = '0;
        endcase
    end

    assign vec_valid_o    = done & ~cur.is_scalar;
    assign vec_dest_o     = cur.dest;
    assign scalar_valid_o = done & cur.is_scalar;
    assign scalar_dest_o  = cur.dest;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the SIMD unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module simd_tb -f build.f -o simd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simd_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

//--- test/simd_ref.svh
// SIMD reference model
`ifndef SIMD_REF_SVH
`define SIMD_REF_SVH

function automatic int ref_lat(vop_t op, sew_t sew);
    if (op != VMUL) begin
        return 1;
    end
    return (sew == SEW_64) ? 3 : 2;  // Multiply needs extra stages
endfunction

function automatic logic ref_is_scalar(vop_t op);
    return op inside {VMV_X_S, VEXT, VCNT};
endfunction

// Element i of width ew, zero-extended
function automatic logic [63:0] elem_get(logic [127:0] v, int ew, int i);
    return 64'((v >> (i * ew)) << (128 - ew) >> (128 - ew));
endfunction

// First source, with rs1 replicated at element width in vx form
function automatic logic [127:0] ref_src1(logic vx, logic [127:0] vs1, logic [63:0] rs1,
                                          sew_t sew);
    logic [127:0] r;
    int           ew;
    ew = 8 << int'(sew);
    r  = '0;
    for (int i = 0; i < 128 / ew; i++) begin
        r = r | ({64'd0, elem_get({64'd0, rs1}, ew, 0)} << (i * ew));
    end
    return vx ? r : vs1;
endfunction

function automatic logic [63:0] ref_elem(vop_t op, logic [63:0] a, logic [63:0] b, int ew);
    logic [63:0] r;
    case (op)
        VADD:       r = a + b;
        VSUB:       r = a - b;
        VAND:       r = a & b;
        VXOR:       r = a ^ b;
        VSEQ, VCNT: r = {63'd0, a == b};
        VMUL:       r = a * b;  // Low half of the product
        default:    r = '0;
    endcase
    return elem_get({64'd0, r}, ew, 0);
endfunction

// Masked vector result, unmasked elements keep old_vd
function automatic logic [127:0] ref_vector(vop_t op, sew_t sew, logic [127:0] src1,
                                            logic [127:0] vs2, logic [127:0] old_vd,
                                            logic [15:0] vm);
    logic [127:0] r;
    logic [127:0] field;
    logic [63:0]  e;
    int           ew;
    ew = 8 << int'(sew);
    r  = old_vd;
    for (int i = 0; i < 128 / ew; i++) begin
        if (vm[i]) begin
            field = {64'd0, elem_get({128{1'b1}}, ew, 0)} << (i * ew);
            e     = ref_elem(op, elem_get(src1, ew, i), elem_get(vs2, ew, i), ew);
            r     = (r & ~field) | ({64'd0, e} << (i * ew));
        end
    end
    return r;
endfunction

function automatic logic [63:0] ref_scalar(vop_t op, sew_t sew, logic [127:0] src1,
                                           logic [127:0] vs2, logic [63:0] rs1);
    logic [63:0] n;
    logic        run;
    int          ew;
    int          cnt;
    ew  = 8 << int'(sew);
    cnt = 128 / ew;
    n   = '0;
    run = 1'b1;
    case (op)
        VMV_X_S: n = elem_get(vs2, ew, 0);
        VEXT: begin
            if (rs1 < 64'(cnt)) begin  // Out of range gives zero
                n = elem_get(vs2, ew, int'(rs1));
            end
        end
        VCNT: begin
            for (int i = 0; i < cnt; i++) begin
                run = run && (elem_get(src1, ew, i) == elem_get(vs2, ew, i));
                if (run) begin
                    n = n + 64'd1;
                end
            end
        end
        default: n = '0;
    endcase
    return n;
endfunction

`endif

//--- test/simd_tb.sv
// SIMD unit testbench
module simd_tb import simd_pkg::*; ();

    `include "simd_ref.svh"

    logic         clk_i;
    logic         rstn_i;
    logic         valid_i;
    vop_t         op_i;
    sew_t         sew_i;
    logic         vx_form_i;
    logic [127:0] vs1_i;
    logic [127:0] vs2_i;
    logic [127:0] old_vd_i;
    logic [63:0]  rs1_i;
    logic [15:0]  vm_i;
    logic [4:0]   dest_i;
    logic         ready_o;
    logic         vec_valid_o;
    logic [127:0] vd_o;
    logic [4:0]   vec_dest_o;
    logic         scalar_valid_o;
    logic [63:0]  rd_result_o;
    logic [4:0]   scalar_dest_o;

    // Expected results, indexed by due cycle modulo 4
    logic         pend_q       [4];
    logic         exp_scalar_q [4];
    logic [127:0] exp_vd_q     [4];
    logic [63:0]  exp_rd_q     [4];
    logic [4:0]   exp_dest_q   [4];
    int           cyc = 0;
    int           errors = 0;
    int           timeouts = 0;
    int           accepted = 0;
    int           stalls = 0;

    simd_unit_top simd_unit_top_i (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic logic [127:0] rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // First n elements from a, the rest from b
    function automatic logic [127:0] keep_leading(logic [127:0] a, logic [127:0] b, sew_t sew,
                                                  int n);
        logic [127:0] r;
        int           ew;
        ew = 8 << int'(sew);
        for (int i = 0; i < 128; i++) begin
            r[i] = (i / ew < n) ? a[i] : b[i];
        end
        return r;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            n += int'(pend_q[i]);
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Hold the instruction until ready_o is seen high before an edge
    task automatic wait_accept();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < 8) begin
            @(negedge clk_i);
            taken = ready_o;
            @(posedge clk_i);
            #1;
            waited++;
        end
        assert (taken) else begin
            $display("Timeout at %0t: instruction not accepted within 8 cycles", $time);
            timeouts++;
            errors++;
        end
    endtask

    task automatic send_random(input vop_t op, input sew_t sew, input logic vx, input int run);
        logic [127:0] src1;
        int           n;
        op_i      = op;
        sew_i     = sew;
        vx_form_i = vx;
        vs1_i     = rand_vec();
        old_vd_i  = rand_vec();
        vm_i      = 16'($urandom);
        dest_i    = 5'($urandom);
        rs1_i     = {$urandom, $urandom};
        if (op == VEXT && $urandom_range(0, 3) != 0) begin
            rs1_i = 64'($urandom_range(0, 19));  // Mostly near the element count
        end
        src1  = ref_src1(vx, vs1_i, rs1_i, sew);
        n     = (run < 0) ? int'($urandom_range(0, 16)) : run;
        vs2_i = (op == VSEQ || op == VCNT) ? keep_leading(src1, rand_vec(), sew, n) : rand_vec();
        valid_i = 1'b1;
        wait_accept();
        valid_i = 1'b0;
    endtask

    // Compare at the falling edge, where inputs and outputs are settled
    always @(negedge clk_i) begin
        int           slot;
        int           due;
        logic         got;
        logic [127:0] src1;
        if (rstn_i) begin
            slot = cyc % 4;
            assert (!(vec_valid_o && scalar_valid_o)) else begin
                $display("Two results presented in one cycle at %0t", $time);
                errors++;
            end
            if (pend_q[slot]) begin
                got = exp_scalar_q[slot] ? scalar_valid_o : vec_valid_o;
                assert (got === 1'b1) else begin
                    $display("Result for dest %0d missing at %0t", exp_dest_q[slot], $time);
                    errors++;
                end
                if (got === 1'b1 && exp_scalar_q[slot]) begin
                    check_value("rd_result_o", 128'(exp_rd_q[slot]), 128'(rd_result_o));
                    check_value("scalar_dest_o", 128'(exp_dest_q[slot]), 128'(scalar_dest_o));
                end else if (got === 1'b1) begin
                    check_value("vd_o", exp_vd_q[slot], vd_o);
                    check_value("vec_dest_o", 128'(exp_dest_q[slot]), 128'(vec_dest_o));
                end
                pend_q[slot] = 1'b0;
            end else begin
                assert (!vec_valid_o && !scalar_valid_o) else begin
                    $display("Unexpected result at %0t with nothing due", $time);
                    errors++;
                end
            end
            due = (cyc + ref_lat(op_i, sew_i)) % 4;
            check_value("ready_o", 128'(!pend_q[due]), 128'(ready_o));
            if (valid_i && !ready_o)
                stalls++;
            if (valid_i && ready_o) begin
                src1              = ref_src1(vx_form_i, vs1_i, rs1_i, sew_i);
                pend_q[due]       = 1'b1;
                exp_scalar_q[due] = ref_is_scalar(op_i);
                exp_vd_q[due]     = ref_vector(op_i, sew_i, src1, vs2_i, old_vd_i, vm_i);
                exp_rd_q[due]     = ref_scalar(op_i, sew_i, src1, vs2_i, rs1_i);
                exp_dest_q[due]   = dest_i;
                accepted++;
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h7aa5_7c77));
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        valid_i   = 1'b0;
        op_i      = VADD;
        sew_i     = SEW_8;
        vx_form_i = 1'b0;
        vs1_i     = '0;
        vs2_i     = '0;
        old_vd_i  = '0;
        rs1_i     = '0;
        vm_i      = '0;
        dest_i    = '0;
        for (int i = 0; i < 4; i++) begin
            pend_q[i] = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        check_value("ready_o", 128'(1'b1), 128'(ready_o));
        check_value("vec_valid_o", '0, 128'(vec_valid_o));
        check_value("scalar_valid_o", '0, 128'(scalar_valid_o));

        // ALU ops at every SEW, vector and vx form
        for (int o = 0; o <= 4; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (4) begin
                    send_random(vop_t'(o), sew_t'(s), 1'b0, -1);
                    send_random(vop_t'(o), sew_t'(s), 1'b1, -1);
                end
            end
        end
        // Multiply, then ALU ops right behind it
        for (int s = 0; s < 4; s++) begin
            repeat (4) send_random(VMUL, sew_t'(s), 1'($urandom_range(0, 1)), -1);
            send_random(VMUL, sew_t'(s), 1'b1, -1);
            send_random(VADD, SEW_8, 1'b0, -1);
            send_random(VXOR, SEW_32, 1'b1, -1);
        end
        // Scalar results with zero, partial and full runs
        for (int s = 0; s < 4; s++) begin
            send_random(VMV_X_S, sew_t'(s), 1'b0, -1);
            repeat (6) send_random(VEXT, sew_t'(s), 1'b0, -1);
            send_random(VCNT, sew_t'(s), 1'b0, 0);
            send_random(VCNT, sew_t'(s), 1'b1, 1);
            send_random(VCNT, sew_t'(s), 1'b0, 16);
        end
        repeat (2000) begin
            send_random(vop_t'($urandom_range(0, 8)), sew_t'($urandom_range(0, 3)),
                        1'($urandom_range(0, 1)), -1);
        end

        valid_i = 1'b0;
        waited  = 0;
        while (pending_count() != 0 && waited < 10) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        assert (pending_count() == 0) else begin
            $display("Expected results still pending at the end of the run");
            errors++;
        end
        assert (stalls > 0) else begin
            $display("ready_o never held back an instruction");
            errors++;
        end
        $display("Summary: %0d errors, %0d timeouts, %0d accepted, %0d stalls",
                 errors, timeouts, accepted, stalls);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
